// ==== Bender.yml ====
package:
  name: ro_read

sources:
  - verilog/ro_pkg.sv
  - verilog/id_free_list.sv
  - verilog/ro_request_split.sv
  - verilog/ro_context_store.sv
  - verilog/ro_resp_unpack.sv
  - verilog/ro_read_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/ro_mem_model.sv
      - test/tb_ro_read.sv

// ==== files.f ====
verilog/ro_pkg.sv
verilog/id_free_list.sv
verilog/ro_request_split.sv
verilog/ro_context_store.sv
verilog/ro_resp_unpack.sv
verilog/ro_read_top.sv
test/tb_clock.sv
test/ro_mem_model.sv
test/tb_ro_read.sv

// ==== test/ro_mem_model.sv ====
`default_nettype none

module ro_mem_model #(
   parameter int          LOG_N_IDS = 3,
   parameter logic [31:0] SEED      = 32'hf8e2_4272
) (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         arvalid,
   output logic                         arready,
   input  ro_pkg::addr_t                araddr,
   input  logic [LOG_N_IDS-1:0]         arid,
   output logic                         rvalid,
   input  logic                         rready,
   output logic [LOG_N_IDS-1:0]         rid,
   output logic [ro_pkg::LINE_BITS-1:0] rdata,
   output int                           ar_count
);

   timeunit 1ns;
   timeprecision 100ps;

   import ro_pkg::*;

   int                   seed = SEED;
   addr_t                pend_addr [$];   // accepted bursts, answered in order
   logic [LOG_N_IDS-1:0] pend_id   [$];

   // word n of memory holds n
   function automatic logic [LINE_BITS-1:0] line_data(input addr_t addr);
      logic [LINE_BITS-1:0] beat;
      beat = '0;
      for (int i = 0; i < int'(LINE_WORDS); i++) begin
         beat[32*i +: 32] = (addr >> 2) + i;
      end
      return beat;
   endfunction

   initial begin
      arready  = 1'b0;
      rvalid   = 1'b0;
      rid      = '0;
      rdata    = '0;
      ar_count = 0;
   end

   always @(posedge clk) begin
      if (!rstn) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         if (rvalid && rready) begin
            rvalid <= 1'b0;
         end
         // next beat only once the current one is gone
         if ((!rvalid || rready) && (pend_addr.size() > 0) && (($random(seed) & 3) != 0)) begin
            rvalid <= 1'b1;
            rid    <= pend_id.pop_front();
            rdata  <= line_data(pend_addr.pop_front());
         end
         if (arvalid && arready) begin
            pend_addr.push_back(araddr);
            pend_id.push_back(arid);
            ar_count <= ar_count + 1;
         end
         arready <= $random(seed) & 1;
      end
   end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS = 8
) (
   output logic clk,
   output logic rstn
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      rstn = 1'b0;
      repeat (2) @(posedge clk);
      rstn <= 1'b1;   // released on the edge after two cycles
   end

endmodule

`default_nettype wire

// ==== test/tb_ro_read.sv ====
`default_nettype none

module tb_ro_read;

   timeunit 1ns;
   timeprecision 100ps;

   import ro_pkg::*;

   localparam int          LOG_N_IDS     = 3;
   localparam int          LOG_N_THREADS = 2;
   localparam int          CLK_PERIOD    = 8;
   localparam logic [31:0] SEED          = 32'hf8e2_4272;
   localparam int          N_ROWS        = 12;

   typedef struct packed {
      logic [7:0] tag;
      addr_t      addr;
      elem_size_e size;
      logic [7:0] n_elems;   // count minus one
      logic [8:0] n_exp;     // elements expected back
   } row_t;

   row_t rows [N_ROWS] = '{
      '{8'h01, 32'h0000_0100, ELEM_W32, 8'd3,   9'd4},     // inside one line
      '{8'h02, 32'h0000_0134, ELEM_W32, 8'd0,   9'd1},
      '{8'h03, 32'h0000_01f8, ELEM_W32, 8'd9,   9'd10},    // two lines
      '{8'h04, 32'h0000_0304, ELEM_W32, 8'd40,  9'd41},
      '{8'h05, 32'h0000_0400, ELEM_W64, 8'd7,   9'd8},     // one full line
      '{8'h06, 32'h0000_0438, ELEM_W64, 8'd5,   9'd6},
      '{8'h07, 32'h0000_05c0, ELEM_W64, 8'd31,  9'd32},
      '{8'h08, 32'h0000_023c, ELEM_W32, 8'd0,   9'd1},     // last word of a line
      '{8'h09, 32'h0000_07fc, ELEM_W32, 8'd1,   9'd2},
      '{8'h0a, 32'h0000_1000, ELEM_W32, 8'd255, 9'd256},   // sixteen lines
      '{8'h0b, 32'h0000_2008, ELEM_W64, 8'd2,   9'd3},
      '{8'h0c, 32'h0000_009c, ELEM_W32, 8'd2,   9'd3}
   };

   logic                 clk;
   logic                 rstn;
   logic                 req_valid;
   logic                 req_ready;
   ro_req_t              req;
   logic                 arvalid;
   logic                 arready;
   addr_t                araddr;
   logic [LOG_N_IDS-1:0] arid;
   logic                 rvalid;
   logic                 rready;
   logic [LOG_N_IDS-1:0] rid;
   logic [LINE_BITS-1:0] rdata;
   logic                 out_valid;
   logic                 out_ready;
   ro_out_t              out;
   logic                 idle;
   int                   ar_count;

   int      seed = SEED;
   ro_out_t exp_q [$];
   ro_out_t expect_elem;
   int      exp_ars  = 0;

   tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_clk (.clk(clk), .rstn(rstn));

   ro_read_top #(
      .LOG_N_IDS     (LOG_N_IDS),
      .LOG_N_THREADS (LOG_N_THREADS)
   ) i_dut (
      .clk, .rstn, .req_valid, .req_ready, .req,
      .arvalid, .arready, .araddr, .arid,
      .rvalid, .rready, .rid, .rdata,
      .out_valid, .out_ready, .out, .idle
   );

   ro_mem_model #(.LOG_N_IDS(LOG_N_IDS), .SEED(SEED)) i_mem (
      .clk, .rstn, .arvalid, .arready, .araddr, .arid,
      .rvalid, .rready, .rid, .rdata, .ar_count
   );

   task automatic abort_run();
      $display("Done: errors found");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
         abort_run();
      end
   endtask

   function automatic int lines_touched(input addr_t addr, input int words);
      addr_t last_byte;
      last_byte = addr + addr_t'(words * 4) - 1;
      return int'(last_byte[31:6] - addr[31:6]) + 1;
   endfunction

   // element k of a request starts at addr + k * element bytes
   task automatic build_expected();
      ro_out_t    elem;
      logic [31:0] word;
      int          words;
      for (int r = 0; r < N_ROWS; r++) begin
         words = int'(rows[r].n_exp) * ((rows[r].size == ELEM_W64) ? 2 : 1);
         exp_ars += lines_touched(rows[r].addr, words);
         for (int k = 0; k < int'(rows[r].n_exp); k++) begin
            elem.tag  = rows[r].tag;
            elem.last = (k == int'(rows[r].n_exp) - 1);
            if (rows[r].size == ELEM_W64) begin
               word      = (rows[r].addr >> 2) + 2 * k;
               elem.data = {word + 32'd1, word};   // lower address in the low half
            end else begin
               word      = (rows[r].addr >> 2) + k;
               elem.data = {32'b0, word};
            end
            exp_q.push_back(elem);
         end
      end
   endtask

   always @(posedge clk) begin
      if (!rstn) begin
         out_ready <= 1'b0;
      end else begin
         out_ready <= ($random(seed) & 3) != 0;
      end
   end

   // scoreboard
   always @(posedge clk) begin
      if (rstn && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("output element at %0t ns with no request outstanding", $time);
            abort_run();
         end else begin
            expect_elem = exp_q.pop_front();
            check_value(out.data, expect_elem.data, "element data");
            check_value(out.tag, expect_elem.tag, "element tag");
            check_value(out.last, expect_elem.last, "last flag");
         end
      end
   end

   initial begin
      #(200 * N_ROWS * CLK_PERIOD);
      $display("timeout: requests did not complete within %0d cycles", 200 * N_ROWS);
      abort_run();
   end

   initial begin
      req_valid = 1'b0;
      req       = '0;
      out_ready = 1'b0;
      build_expected();
      wait (rstn);
      @(posedge clk);
      check_value(idle, 1'b1, "idle after reset");
      for (int r = 0; r < N_ROWS; r++) begin
         req_valid   <= 1'b1;
         req.tag     <= rows[r].tag;
         req.addr    <= rows[r].addr;
         req.size    <= rows[r].size;
         req.n_elems <= rows[r].n_elems;
         @(posedge clk);
         while (!req_ready) @(posedge clk);
      end
      req_valid <= 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      @(posedge clk);
      check_value(idle, 1'b1, "idle after last element");
      check_value(out_valid, 1'b0, "out_valid after last element");
      check_value(ar_count, exp_ars, "AR beats");
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/id_free_list.sv ====
`default_nettype none

module id_free_list #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 add,
   input  logic [LOG_DEPTH-1:0] add_id,
   input  logic                 take,
   output logic [LOG_DEPTH-1:0] next_id,
   output logic                 empty,
   output logic                 full
);

   localparam int DEPTH = 2 ** LOG_DEPTH;

   logic [LOG_DEPTH-1:0] ids [DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH:0]   count;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < DEPTH; i++) begin
            ids[i] <= LOG_DEPTH'(i);   // every id starts out free
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= {1'b1, {LOG_DEPTH{1'b0}}};
      end else begin
         if (add) begin
            ids[wr_ptr] <= add_id;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (take) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (add && !take) begin
            count <= count + 1'b1;
         end else if (take && !add) begin
            count <= count - 1'b1;
         end
      end
   end

   assign next_id = ids[rd_ptr];
   assign empty   = (count == '0);
   assign full    = count[LOG_DEPTH];

   // an id can only come back after it was handed out
   no_add_when_full: assert property (@(posedge clk) disable iff (!rstn) !(add && full));

endmodule

`default_nettype wire

// ==== verilog/ro_context_store.sv ====
`default_nettype none

module ro_context_store #(
   parameter int LOG_N_IDS     = 3,
   parameter int LOG_N_THREADS = 2
) (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     mshr_wr,
   input  logic [LOG_N_IDS-1:0]     wr_id,
   input  ro_pkg::ro_mshr_t         mshr_entry,
   input  logic [LOG_N_IDS-1:0]     rd_id,
   output ro_pkg::ro_mshr_t         rd_entry,
   input  logic                     alloc,
   input  logic [LOG_N_THREADS-1:0] alloc_thread,
   input  logic [7:0]               alloc_tag,
   input  ro_pkg::word_cnt_t        alloc_words,
   input  logic                     consume,
   input  logic [LOG_N_THREADS-1:0] consume_thread,
   input  logic [1:0]               consume_words,
   output logic [7:0]               thread_tag,
   output ro_pkg::word_cnt_t        thread_remaining
);

   import ro_pkg::*;

   localparam int N_IDS     = 2 ** LOG_N_IDS;
   localparam int N_THREADS = 2 ** LOG_N_THREADS;

   ro_mshr_t   mshr_tab  [N_IDS];      // one entry per outstanding read
   logic [7:0] tag_tab   [N_THREADS];
   word_cnt_t  remaining [N_THREADS];

   always_ff @(posedge clk) begin
      if (mshr_wr) begin
         mshr_tab[wr_id] <= mshr_entry;
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         tag_tab[alloc_thread] <= alloc_tag;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < N_THREADS; i++) begin
            remaining[i] <= '0;
         end
      end else begin
         for (int i = 0; i < N_THREADS; i++) begin
            if (alloc && (alloc_thread == i)) begin
               remaining[i] <= alloc_words;
            end else if (consume && (consume_thread == i)) begin
               remaining[i] <= remaining[i] - word_cnt_t'(consume_words);
            end
         end
      end
   end

   assign rd_entry         = mshr_tab[rd_id];
   assign thread_tag       = tag_tab[consume_thread];   // thread of the beat being unpacked
   assign thread_remaining = remaining[consume_thread];

   // the unpacker never emits more words than the request asked for
   no_underflow: assert property (@(posedge clk) disable iff (!rstn)
      consume |-> thread_remaining >= word_cnt_t'(consume_words));

endmodule

`default_nettype wire

// ==== verilog/ro_pkg.sv ====
`default_nettype none

package ro_pkg;

   localparam logic [4:0] LINE_WORDS = 5'd16;   // 32-bit words in a 64-byte line
   localparam int         LINE_BITS  = 512;

   typedef logic [31:0] addr_t;
   typedef logic [3:0]  word_idx_t;
   typedef logic [15:0] word_mask_t;   // one bit per word of a line

   // words still owed to a request, up to 256 elements of 64 bits
   typedef logic [9:0] word_cnt_t;

   // encoded as the AXI size code
   typedef enum logic [2:0] {
      ELEM_W32 = 3'd2,
      ELEM_W64 = 3'd3
   } elem_size_e;

   typedef struct packed {
      logic [7:0] tag;
      addr_t      addr;
      elem_size_e size;
      logic [7:0] n_elems;   // count minus one, like arlen
   } ro_req_t;

   typedef struct packed {
      logic [7:0] thread;   // only the low thread-id bits are used
      word_mask_t valid_words;
      elem_size_e size;
   } ro_mshr_t;

   typedef struct packed {
      logic [63:0] data;   // upper half zero for 32-bit elements
      logic [7:0]  tag;
      logic        last;
   } ro_out_t;

endpackage

`default_nettype wire

// ==== verilog/ro_read_top.sv ====
`default_nettype none

module ro_read_top #(
   parameter int LOG_N_IDS     = 3,
   parameter int LOG_N_THREADS = 2
) (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         req_valid,
   output logic                         req_ready,
   input  ro_pkg::ro_req_t              req,
   output logic                         arvalid,
   input  logic                         arready,
   output ro_pkg::addr_t                araddr,
   output logic [LOG_N_IDS-1:0]         arid,
   input  logic                         rvalid,
   output logic                         rready,
   input  logic [LOG_N_IDS-1:0]         rid,
   input  logic [ro_pkg::LINE_BITS-1:0] rdata,
   output logic                         out_valid,
   input  logic                         out_ready,
   output ro_pkg::ro_out_t              out,
   output logic                         idle
);

   import ro_pkg::*;

   logic                     alloc;
   logic [LOG_N_THREADS-1:0] alloc_thread;
   logic [7:0]               alloc_tag;
   word_cnt_t                alloc_words;
   logic                     mshr_wr;
   ro_mshr_t                 mshr_entry;
   logic [LOG_N_IDS-1:0]     rd_id;
   ro_mshr_t                 rd_entry;
   logic [7:0]               thread_tag;
   word_cnt_t                thread_remaining;
   logic                     consume;
   logic [LOG_N_THREADS-1:0] consume_thread;
   logic [1:0]               consume_words;
   logic                     release_thread;

   ro_request_split #(
      .LOG_N_IDS     (LOG_N_IDS),
      .LOG_N_THREADS (LOG_N_THREADS)
   ) i_split (
      .clk,
      .rstn,
      .req_valid,
      .req_ready,
      .req,
      .arvalid,
      .arready,
      .araddr,
      .arid,
      .rvalid,
      .rready,
      .rid,
      .alloc,
      .alloc_thread,
      .alloc_tag,
      .alloc_words,
      .mshr_wr,
      .mshr_entry,
      .thread_release (release_thread),
      .release_id     (consume_thread),   // the releasing element belongs to this thread
      .idle
   );

   ro_context_store #(
      .LOG_N_IDS     (LOG_N_IDS),
      .LOG_N_THREADS (LOG_N_THREADS)
   ) i_ctx (
      .clk,
      .rstn,
      .mshr_wr,
      .wr_id (arid),
      .mshr_entry,
      .rd_id,
      .rd_entry,
      .alloc,
      .alloc_thread,
      .alloc_tag,
      .alloc_words,
      .consume,
      .consume_thread,
      .consume_words,
      .thread_tag,
      .thread_remaining
   );

   ro_resp_unpack #(
      .LOG_N_IDS     (LOG_N_IDS),
      .LOG_N_THREADS (LOG_N_THREADS)
   ) i_unpack (
      .clk,
      .rstn,
      .rvalid,
      .rready,
      .rid,
      .rdata,
      .rd_id,
      .rd_entry,
      .thread_tag,
      .thread_remaining,
      .consume,
      .consume_thread,
      .consume_words,
      .release_thread,
      .out_valid,
      .out_ready,
      .out
   );

endmodule

`default_nettype wire

// ==== verilog/ro_request_split.sv ====
`default_nettype none

module ro_request_split #(
   parameter int LOG_N_IDS     = 3,
   parameter int LOG_N_THREADS = 2
) (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     req_valid,
   output logic                     req_ready,
   input  ro_pkg::ro_req_t          req,
   output logic                     arvalid,
   input  logic                     arready,
   output ro_pkg::addr_t            araddr,
   output logic [LOG_N_IDS-1:0]     arid,
   input  logic                     rvalid,
   input  logic                     rready,
   input  logic [LOG_N_IDS-1:0]     rid,
   output logic                     alloc,
   output logic [LOG_N_THREADS-1:0] alloc_thread,
   output logic [7:0]               alloc_tag,
   output ro_pkg::word_cnt_t        alloc_words,
   output logic                     mshr_wr,
   output ro_pkg::ro_mshr_t         mshr_entry,
   input  logic                     thread_release,
   input  logic [LOG_N_THREADS-1:0] release_id,
   output logic                     idle
);

   import ro_pkg::*;

   typedef enum logic {
      SPLIT_IDLE,
      SPLIT_BURST
   } split_state_e;

   split_state_e             state;
   addr_t                    cur_addr;
   word_cnt_t                cur_words;
   elem_size_e               cur_size;
   logic [LOG_N_THREADS-1:0] cur_thread;

   logic [LOG_N_THREADS-1:0] free_thread;
   logic                     thread_empty;
   logic                     rid_empty;
   logic                     req_hs;
   logic                     ar_hs;
   word_idx_t                word_off;
   logic [4:0]               room;
   logic [4:0]               burst_words;
   logic                     last_burst;
   word_mask_t               burst_mask;

   id_free_list #(
      .LOG_DEPTH(LOG_N_IDS)
   ) i_rid_list (
      .clk     (clk),
      .rstn    (rstn),
      .add     (rvalid && rready),   // id comes back once its line is in
      .add_id  (rid),
      .take    (ar_hs),
      .next_id (arid),
      .empty   (rid_empty),
      .full    ()
   );

   id_free_list #(
      .LOG_DEPTH(LOG_N_THREADS)
   ) i_thread_list (
      .clk     (clk),
      .rstn    (rstn),
      .add     (thread_release),
      .add_id  (release_id),
      .take    (req_hs),
      .next_id (free_thread),
      .empty   (thread_empty),
      .full    (idle)
   );

   // burst geometry of the current position
   always_comb begin
      word_off    = cur_addr[5:2];
      room        = LINE_WORDS - {1'b0, word_off};
      last_burst  = (cur_words <= word_cnt_t'(room));
      burst_words = last_burst ? cur_words[4:0] : room;
      for (int i = 0; i < LINE_WORDS; i++) begin
         burst_mask[i] = (i >= word_off) && (i < word_off + burst_words);
      end
   end

   always_comb begin
      alloc_words = word_cnt_t'(req.n_elems) + word_cnt_t'(1);
      if (req.size == ELEM_W64) begin
         alloc_words = alloc_words << 1;   // two words per element
      end
   end

   assign arvalid   = (state == SPLIT_BURST) && !rid_empty;
   assign araddr    = {cur_addr[31:6], 6'b0};
   assign ar_hs     = arvalid && arready;
   assign req_ready = !thread_empty && ((state == SPLIT_IDLE) || (ar_hs && last_burst));
   assign req_hs    = req_valid && req_ready;

   assign alloc        = req_hs;
   assign alloc_thread = free_thread;
   assign alloc_tag    = req.tag;

   assign mshr_wr = ar_hs;
   always_comb begin
      mshr_entry                           = '0;
      mshr_entry.thread[LOG_N_THREADS-1:0] = cur_thread;
      mshr_entry.valid_words               = burst_mask;
      mshr_entry.size                      = cur_size;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= SPLIT_IDLE;
      end else if (req_hs) begin
         state <= SPLIT_BURST;
      end else if (ar_hs && last_burst) begin
         state <= SPLIT_IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (req_hs) begin
         cur_addr   <= req.addr;
         cur_words  <= alloc_words;
         cur_size   <= req.size;
         cur_thread <= free_thread;
      end else if (ar_hs) begin
         cur_addr  <= cur_addr + addr_t'({burst_words, 2'b00});   // lands on next line
         cur_words <= cur_words - word_cnt_t'(burst_words);
      end
   end

   ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid));

endmodule

`default_nettype wire

// ==== verilog/ro_resp_unpack.sv ====
`default_nettype none

module ro_resp_unpack #(
   parameter int LOG_N_IDS     = 3,
   parameter int LOG_N_THREADS = 2
) (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         rvalid,
   output logic                         rready,
   input  logic [LOG_N_IDS-1:0]         rid,
   input  logic [ro_pkg::LINE_BITS-1:0] rdata,
   output logic [LOG_N_IDS-1:0]         rd_id,
   input  ro_pkg::ro_mshr_t             rd_entry,
   input  logic [7:0]                   thread_tag,
   input  ro_pkg::word_cnt_t            thread_remaining,
   output logic                         consume,
   output logic [LOG_N_THREADS-1:0]     consume_thread,
   output logic [1:0]                   consume_words,
   output logic                         release_thread,
   output logic                         out_valid,
   input  logic                         out_ready,
   output ro_pkg::ro_out_t              out
);

   import ro_pkg::*;

   logic                     held;
   logic [LINE_BITS-1:0]     beat_data;
   word_mask_t               beat_mask;
   elem_size_e               beat_size;
   logic [LOG_N_THREADS-1:0] beat_thread;

   word_idx_t  lo_idx;
   word_idx_t  hi_idx;
   logic [1:0] n_take;
   word_mask_t take_mask;
   word_mask_t next_mask;
   logic       r_hs;
   logic       out_hs;
   logic       beat_done;

   // lowest valid word left in the held line
   always_comb begin
      lo_idx = '0;
      for (int i = LINE_WORDS - 1; i >= 0; i--) begin
         if (beat_mask[i]) begin
            lo_idx = word_idx_t'(i);
         end
      end
   end

   assign hi_idx = {lo_idx[3:1], 1'b1};   // 64-bit elements are aligned

   always_comb begin
      n_take            = (beat_size == ELEM_W64) ? 2'd2 : 2'd1;
      take_mask         = '0;
      take_mask[lo_idx] = 1'b1;
      if (beat_size == ELEM_W64) begin
         take_mask[hi_idx] = 1'b1;
      end
      next_mask = beat_mask & ~take_mask;
   end

   always_comb begin
      out.data = {32'b0, beat_data[32*lo_idx +: 32]};
      if (beat_size == ELEM_W64) begin
         out.data[63:32] = beat_data[32*hi_idx +: 32];   // higher address in upper half
      end
      out.tag  = thread_tag;
      out.last = (thread_remaining == word_cnt_t'(n_take));
   end

   assign out_valid = held;
   assign out_hs    = out_valid && out_ready;
   assign beat_done = out_hs && (next_mask == '0);
   assign rready    = !held || beat_done;
   assign r_hs      = rvalid && rready;
   assign rd_id     = rid;

   assign consume        = out_hs;
   assign consume_thread = beat_thread;
   assign consume_words  = n_take;
   assign release_thread = out_hs && out.last;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         held <= 1'b0;
      end else if (r_hs) begin
         held <= 1'b1;
      end else if (beat_done) begin
         held <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (r_hs) begin
         beat_data   <= rdata;
         beat_mask   <= rd_entry.valid_words;
         beat_size   <= rd_entry.size;
         beat_thread <= rd_entry.thread[LOG_N_THREADS-1:0];
      end else if (out_hs) begin
         beat_mask <= next_mask;
      end
   end

   // tag and last come from the context store and must not move either
   out_hold: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

`default_nettype wire
